/* logic/mini_rv32_pkg.sv */
// RV32I subset only: no shifts, no byte or halfword access, no CSRs; all addresses word aligned
package mini_rv32_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // Major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } core_state_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLT,
        SLTU,
        XOR,
        OR,
        AND,
        PASS_B,
        PC_PLUS_B,
        LINK
    } alu_op_t;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction formats

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_view_t;

    // Also carries the B format, with the bits scrambled differently
    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_view_t;

    // Also carries the J format
    typedef struct packed {
        logic [19:0]           imm;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_view_t;

    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
        s_view_t s_view;
        u_view_t u_view;
    } instr_word_u;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath and port bundles

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
        alu_op_t               alu_op;
        logic                  use_imm;
        logic [2:0]            funct3;
        logic                  is_branch;
        logic                  is_jal;
        logic                  is_jalr;
        logic                  is_load;
        logic                  is_store;
        logic                  writes_rd;
    } issue_packet_t;

    typedef struct packed {
        logic            en;
        logic [XLEN-1:0] addr;
    } imem_req_t;

    typedef struct packed {
        logic            en;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } dmem_req_t;

endpackage

/* logic/core_control.sv */
// One instruction in flight; 4 cycles per instruction, 5 for a load, no stalls of any kind
`timescale 1ns/100ps

module core_control (
    input  logic                          clk,
    input  logic                          rst,
    input  mini_rv32_pkg::issue_packet_t  issue,
    output mini_rv32_pkg::core_state_t    state,
    output logic                          fetch_en,
    output logic                          decode_en,
    output logic                          pc_update,
    output logic                          mem_en,
    output logic                          wb_en
);

    mini_rv32_pkg::core_state_t next_state;

    always_comb begin
        next_state = state;
        case (state)
            mini_rv32_pkg::FETCH:     next_state = mini_rv32_pkg::DECODE;
            mini_rv32_pkg::DECODE:    next_state = mini_rv32_pkg::EXECUTE;
            mini_rv32_pkg::EXECUTE:   next_state = issue.is_load ? mini_rv32_pkg::MEMORY
                                                                 : mini_rv32_pkg::WRITEBACK;
            mini_rv32_pkg::MEMORY:    next_state = mini_rv32_pkg::WRITEBACK;
            mini_rv32_pkg::WRITEBACK: next_state = mini_rv32_pkg::FETCH;
            default:                  next_state = mini_rv32_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mini_rv32_pkg::FETCH;
        end else begin
            state <= next_state;
        end
    end

    // State already reads FETCH in reset, so the request is gated by rst
    assign fetch_en  = (state == mini_rv32_pkg::FETCH) && !rst;
    assign decode_en = (state == mini_rv32_pkg::DECODE);
    assign pc_update = (state == mini_rv32_pkg::EXECUTE);
    assign wb_en     = (state == mini_rv32_pkg::WRITEBACK);

    // Store writes in EXECUTE, load reads in MEMORY
    assign mem_en = ((state == mini_rv32_pkg::EXECUTE) && issue.is_store) ||
                    (state == mini_rv32_pkg::MEMORY);

endmodule

/* logic/fetch_unit.sv */
// PC is assumed word aligned; no misaligned-target check is made
`timescale 1ns/100ps

module fetch_unit (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            fetch_en,
    input  logic                            pc_update,
    input  logic                            redirect,
    input  logic [mini_rv32_pkg::XLEN-1:0]  target,
    output logic [mini_rv32_pkg::XLEN-1:0]  pc,
    output mini_rv32_pkg::imem_req_t        imem_req
);

    logic [mini_rv32_pkg::XLEN-1:0] next_pc;

    assign next_pc = redirect ? target : pc + mini_rv32_pkg::XLEN'(4);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= mini_rv32_pkg::RESET_PC;
        end else if (pc_update) begin
            pc <= next_pc;
        end
    end

    assign imem_req.en   = fetch_en;
    assign imem_req.addr = pc;

endmodule

/* logic/decode_unit.sv */
// Shifts and every opcode outside the supported set decode to a no-op packet
`timescale 1ns/100ps

module decode_unit (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            decode_en,
    input  logic [mini_rv32_pkg::XLEN-1:0]  imem_rdata,
    input  logic [mini_rv32_pkg::XLEN-1:0]  pc,
    output mini_rv32_pkg::issue_packet_t    issue,
    output logic [mini_rv32_pkg::XLEN-1:0]  pc_of_instr
);

    mini_rv32_pkg::instr_word_u     instr;
    logic [mini_rv32_pkg::XLEN-1:0] imm_i;
    logic [mini_rv32_pkg::XLEN-1:0] imm_s;
    logic [mini_rv32_pkg::XLEN-1:0] imm_b;
    logic [mini_rv32_pkg::XLEN-1:0] imm_u;
    logic [mini_rv32_pkg::XLEN-1:0] imm_j;
    mini_rv32_pkg::alu_op_t         func_op;
    logic                           func_ok;

    // Zero word has an unknown opcode, so reset leaves a no-op behind
    always_ff @(posedge clk) begin
        if (rst) begin
            instr <= '0;
        end else if (decode_en) begin
            instr <= imem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_en) begin
            pc_of_instr <= pc;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Immediates

    assign imm_i = {{20{instr.i_view.imm[11]}}, instr.i_view.imm};
    assign imm_s = {{20{instr.s_view.imm_hi[6]}}, instr.s_view.imm_hi, instr.s_view.imm_lo};
    assign imm_b = {{19{instr.s_view.imm_hi[6]}}, instr.s_view.imm_hi[6],
                    instr.s_view.imm_lo[0], instr.s_view.imm_hi[5:0],
                    instr.s_view.imm_lo[4:1], 1'b0};
    assign imm_u = {instr.u_view.imm, 12'b0};
    assign imm_j = {{11{instr.u_view.imm[19]}}, instr.u_view.imm[19],
                    instr.u_view.imm[7:0], instr.u_view.imm[8],
                    instr.u_view.imm[18:9], 1'b0};

    // funct3 to ALU op, SUB only for register-register with funct7 bit 5
    always_comb begin
        func_ok = 1'b1;
        func_op = mini_rv32_pkg::ADD;
        case (instr.r_view.funct3)
            3'b000: begin
                if (instr.r_view.opcode == mini_rv32_pkg::OPC_OP && instr.r_view.funct7[5]) begin
                    func_op = mini_rv32_pkg::SUB;
                end
            end
            3'b010:  func_op = mini_rv32_pkg::SLT;
            3'b011:  func_op = mini_rv32_pkg::SLTU;
            3'b100:  func_op = mini_rv32_pkg::XOR;
            3'b110:  func_op = mini_rv32_pkg::OR;
            3'b111:  func_op = mini_rv32_pkg::AND;
            default: func_ok = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Issue packet

    always_comb begin
        issue        = '0;
        issue.alu_op = mini_rv32_pkg::ADD;
        issue.rs1    = instr.r_view.rs1;
        issue.rs2    = instr.r_view.rs2;
        issue.funct3 = instr.r_view.funct3;
        case (instr.r_view.opcode)
            mini_rv32_pkg::OPC_LUI, mini_rv32_pkg::OPC_AUIPC: begin
                issue.rd        = instr.u_view.rd;
                issue.imm       = imm_u;
                issue.use_imm   = 1'b1;
                issue.writes_rd = 1'b1;
                issue.alu_op    = (instr.u_view.opcode == mini_rv32_pkg::OPC_LUI) ?
                                  mini_rv32_pkg::PASS_B : mini_rv32_pkg::PC_PLUS_B;
            end
            mini_rv32_pkg::OPC_JAL: begin
                issue.rd        = instr.u_view.rd;
                issue.imm       = imm_j;
                issue.alu_op    = mini_rv32_pkg::LINK;
                issue.is_jal    = 1'b1;
                issue.writes_rd = 1'b1;
            end
            mini_rv32_pkg::OPC_JALR: begin
                issue.rd        = instr.i_view.rd;
                issue.imm       = imm_i;
                issue.alu_op    = mini_rv32_pkg::LINK;
                issue.is_jalr   = 1'b1;
                issue.writes_rd = 1'b1;
            end
            mini_rv32_pkg::OPC_BRANCH: begin
                issue.imm       = imm_b;
                issue.is_branch = 1'b1;
            end
            mini_rv32_pkg::OPC_LOAD: begin
                issue.rd        = instr.i_view.rd;
                issue.imm       = imm_i;
                issue.use_imm   = 1'b1;
                issue.is_load   = 1'b1;
                issue.writes_rd = 1'b1;
            end
            mini_rv32_pkg::OPC_STORE: begin
                issue.imm       = imm_s;
                issue.use_imm   = 1'b1;
                issue.is_store  = 1'b1;
            end
            mini_rv32_pkg::OPC_OP_IMM: begin
                issue.rd        = instr.i_view.rd;
                issue.imm       = imm_i;
                issue.use_imm   = 1'b1;
                issue.alu_op    = func_op;
                issue.writes_rd = func_ok;
            end
            mini_rv32_pkg::OPC_OP: begin
                issue.rd        = instr.r_view.rd;
                issue.alu_op    = func_op;
                issue.writes_rd = func_ok;
            end
            default: begin
                issue.alu_op = mini_rv32_pkg::ADD;
            end
        endcase
    end

endmodule

/* logic/register_file.sv */
// Reads are combinational; a write lands at the end of the writeback cycle
`timescale 1ns/100ps

module register_file (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [mini_rv32_pkg::REG_ADDR_W-1:0]  rs1_addr,
    input  logic [mini_rv32_pkg::REG_ADDR_W-1:0]  rs2_addr,
    input  logic [mini_rv32_pkg::REG_ADDR_W-1:0]  rd_addr,
    input  logic                                  wr_en,
    input  logic                                  writes_rd,
    input  logic [mini_rv32_pkg::XLEN-1:0]        wr_data,
    output logic [mini_rv32_pkg::XLEN-1:0]        rs1_data,
    output logic [mini_rv32_pkg::XLEN-1:0]        rs2_data
);

    // x0 has no storage
    logic [mini_rv32_pkg::XLEN-1:0] regs [1:mini_rv32_pkg::NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < mini_rv32_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && writes_rd && rd_addr != '0) begin
            regs[rd_addr] <= wr_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* logic/alu_unit.sv */
// Combinational; pc must be the address of the instruction being executed
`timescale 1ns/100ps

module alu_unit (
    input  mini_rv32_pkg::issue_packet_t    issue,
    input  logic [mini_rv32_pkg::XLEN-1:0]  rs1_data,
    input  logic [mini_rv32_pkg::XLEN-1:0]  rs2_data,
    input  logic [mini_rv32_pkg::XLEN-1:0]  pc,
    output logic [mini_rv32_pkg::XLEN-1:0]  alu_result
);

    logic [mini_rv32_pkg::XLEN-1:0] op_b;

    assign op_b = issue.use_imm ? issue.imm : rs2_data;

    always_comb begin
        case (issue.alu_op)
            mini_rv32_pkg::ADD:       alu_result = rs1_data + op_b;
            mini_rv32_pkg::SUB:       alu_result = rs1_data - op_b;
            mini_rv32_pkg::SLT:       alu_result = {31'b0, $signed(rs1_data) < $signed(op_b)};
            mini_rv32_pkg::SLTU:      alu_result = {31'b0, rs1_data < op_b};
            mini_rv32_pkg::XOR:       alu_result = rs1_data ^ op_b;
            mini_rv32_pkg::OR:        alu_result = rs1_data | op_b;
            mini_rv32_pkg::AND:       alu_result = rs1_data & op_b;
            // LUI
            mini_rv32_pkg::PASS_B:    alu_result = op_b;
            // AUIPC
            mini_rv32_pkg::PC_PLUS_B: alu_result = pc + op_b;
            // Return address for JAL and JALR
            mini_rv32_pkg::LINK:      alu_result = pc + mini_rv32_pkg::XLEN'(4);
            default:                  alu_result = rs1_data + op_b;
        endcase
    end

endmodule

/* logic/branch_unit.sv */
// No prediction; the target is only meaningful while redirect is high
`timescale 1ns/100ps

module branch_unit (
    input  mini_rv32_pkg::issue_packet_t    issue,
    input  logic [mini_rv32_pkg::XLEN-1:0]  rs1_data,
    input  logic [mini_rv32_pkg::XLEN-1:0]  rs2_data,
    input  logic [mini_rv32_pkg::XLEN-1:0]  pc,
    output logic                            redirect,
    output logic [mini_rv32_pkg::XLEN-1:0]  target
);

    logic                           taken;
    logic [mini_rv32_pkg::XLEN-1:0] jalr_sum;

    always_comb begin
        case (issue.funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data < rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    assign redirect = issue.is_jal || issue.is_jalr || (issue.is_branch && taken);

    assign jalr_sum = rs1_data + issue.imm;
    assign target   = issue.is_jalr ? {jalr_sum[mini_rv32_pkg::XLEN-1:1], 1'b0}
                                    : pc + issue.imm;

endmodule

/* logic/load_store_unit.sv */
// Whole words only; load data is taken straight from the memory, unregistered
`timescale 1ns/100ps

module load_store_unit (
    input  mini_rv32_pkg::issue_packet_t    issue,
    input  logic                            mem_en,
    input  mini_rv32_pkg::core_state_t      state,
    input  logic [mini_rv32_pkg::XLEN-1:0]  alu_result,
    input  logic [mini_rv32_pkg::XLEN-1:0]  rs2_data,
    input  logic [mini_rv32_pkg::XLEN-1:0]  dmem_rdata,
    output mini_rv32_pkg::dmem_req_t        dmem_req,
    output logic [mini_rv32_pkg::XLEN-1:0]  wb_data
);

    // Store writes in EXECUTE, the load read goes out in MEMORY
    assign dmem_req.en    = mem_en;
    assign dmem_req.we    = issue.is_store && (state == mini_rv32_pkg::EXECUTE);
    assign dmem_req.addr  = alu_result;
    assign dmem_req.wdata = rs2_data;

    // Read data arrives in WRITEBACK, one cycle after the MEMORY request
    assign wb_data = issue.is_load ? dmem_rdata : alu_result;

endmodule

/* logic/mini_rv32.sv */
// Multi-cycle core; both memories must return read data exactly one cycle after en
`timescale 1ns/100ps

module mini_rv32 (
    input  logic                               clk,
    input  logic                               rst,
    output mini_rv32_pkg::imem_req_t           imem_req,
    input  logic [mini_rv32_pkg::XLEN-1:0]     imem_rdata,
    output mini_rv32_pkg::dmem_req_t           dmem_req,
    input  logic [mini_rv32_pkg::XLEN-1:0]     dmem_rdata
);

    mini_rv32_pkg::core_state_t   state;
    mini_rv32_pkg::issue_packet_t issue;

    logic fetch_en;
    logic decode_en;
    logic pc_update;
    logic mem_en;
    logic wb_en;
    logic redirect;

    logic [mini_rv32_pkg::XLEN-1:0] pc;
    logic [mini_rv32_pkg::XLEN-1:0] pc_of_instr;
    logic [mini_rv32_pkg::XLEN-1:0] target;
    logic [mini_rv32_pkg::XLEN-1:0] rs1_data;
    logic [mini_rv32_pkg::XLEN-1:0] rs2_data;
    logic [mini_rv32_pkg::XLEN-1:0] alu_result;
    logic [mini_rv32_pkg::XLEN-1:0] wb_data;

    core_control i_core_control (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .state     (state),
        .fetch_en  (fetch_en),
        .decode_en (decode_en),
        .pc_update (pc_update),
        .mem_en    (mem_en),
        .wb_en     (wb_en)
    );

    fetch_unit i_fetch_unit (
        .clk       (clk),
        .rst       (rst),
        .fetch_en  (fetch_en),
        .pc_update (pc_update),
        .redirect  (redirect),
        .target    (target),
        .pc        (pc),
        .imem_req  (imem_req)
    );

    decode_unit i_decode_unit (
        .clk         (clk),
        .rst         (rst),
        .decode_en   (decode_en),
        .imem_rdata  (imem_rdata),
        .pc          (pc),
        .issue       (issue),
        .pc_of_instr (pc_of_instr)
    );

    register_file i_register_file (
        .clk       (clk),
        .rst       (rst),
        .rs1_addr  (issue.rs1),
        .rs2_addr  (issue.rs2),
        .rd_addr   (issue.rd),
        .wr_en     (wb_en),
        .writes_rd (issue.writes_rd),
        .wr_data   (wb_data),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    // PC of the instruction in flight, pc has already moved on by WRITEBACK
    alu_unit i_alu_unit (
        .issue      (issue),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .pc         (pc_of_instr),
        .alu_result (alu_result)
    );

    branch_unit i_branch_unit (
        .issue    (issue),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .pc       (pc_of_instr),
        .redirect (redirect),
        .target   (target)
    );

    load_store_unit i_load_store_unit (
        .issue      (issue),
        .mem_en     (mem_en),
        .state      (state),
        .alu_result (alu_result),
        .rs2_data   (rs2_data),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (dmem_req),
        .wb_data    (wb_data)
    );

endmodule

/* dv/mini_rv32_asserts.sv */
// Checks the memory ports only; assumes every instruction refetches within 5 cycles
`timescale 1ns/100ps

module mini_rv32_asserts (
    input  logic                      clk,
    input  logic                      rst,
    input  mini_rv32_pkg::imem_req_t  imem_req,
    input  mini_rv32_pkg::dmem_req_t  dmem_req
);

    // Cycles without a fetch since the last one
    logic [2:0] fetch_gap;

    always_ff @(posedge clk) begin
        if (rst || imem_req.en) begin
            fetch_gap <= '0;
        end else if (fetch_gap != 3'd7) begin
            fetch_gap <= fetch_gap + 3'd1;
        end
    end

    no_req_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (!imem_req.en && !dmem_req.en))
        else $error("memory request active during reset");

    one_port_at_a_time: assert property (@(posedge clk) disable iff (rst)
        !(imem_req.en && dmem_req.en))
        else $error("instruction and data requests in the same cycle");

    dmem_word_aligned: assert property (@(posedge clk) disable iff (rst)
        dmem_req.en |-> (dmem_req.addr[1:0] == 2'b00))
        else $error("data address not word aligned");

    // Load takes 5 cycles, everything else 4
    fetch_within_5: assert property (@(posedge clk) disable iff (rst)
        (fetch_gap == 3'd4) |-> imem_req.en)
        else $error("no instruction fetch within 5 cycles of the last one");

endmodule

bind mini_rv32 mini_rv32_asserts i_mini_rv32_asserts (
    .clk      (clk),
    .rst      (rst),
    .imem_req (imem_req),
    .dmem_req (dmem_req)
);

/* dv/tb_mini_rv32.sv */
// Memory models hold 256 words each and only see address bits 9:2; run from the project root
`timescale 1ns/100ps

module tb_mini_rv32;

    logic                                  clk;
    logic                                  rst;
    mini_rv32_pkg::imem_req_t              imem_req;
    logic [mini_rv32_pkg::XLEN-1:0]        imem_rdata;
    mini_rv32_pkg::dmem_req_t              dmem_req;
    logic [mini_rv32_pkg::XLEN-1:0]        dmem_rdata;

    logic [mini_rv32_pkg::XLEN-1:0]        imem [0:255];
    logic [mini_rv32_pkg::XLEN-1:0]        dmem [0:255];
    logic [mini_rv32_pkg::XLEN-1:0]        exp_addr [$];
    logic [mini_rv32_pkg::XLEN-1:0]        exp_data [$];

    int num_words   = 0;
    int cycle_count = 0;
    int cycle_limit = 0;
    int quiet_count = 0;

    mini_rv32 i_dut (
        .clk        (clk),
        .rst        (rst),
        .imem_req   (imem_req),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and the value check

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED at %0t: %s is %h, expected %h",
                                        $time, name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test data

    task automatic load_tests();
        int                fd;
        int                n;
        string             line;
        logic [31:0]       a;
        logic [31:0]       d;
        for (int i = 0; i < 256; i++) begin
            // Opcode field zero, so a stray fetch is a no-op
            imem[i] = {i[22:0], 2'b00, 7'b0};
            dmem[i] = {16'hdead, i[13:0], 2'b00};
        end
        fd = $fopen("dv/mini_rv32_tests.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open the tests file dv/mini_rv32_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0 && line[0] == "I" && num_words < 256) begin
                    n = $sscanf(line, "I %h", d);
                    imem[num_words] = d;
                    num_words++;
                end else if (n > 0 && line.len() > 0 && line[0] == "D") begin
                    n = $sscanf(line, "D %h %h", a, d);
                    dmem[a[9:2]] = d;
                end else if (n > 0 && line.len() > 0 && line[0] == "E") begin
                    n = $sscanf(line, "E %h %h", a, d);
                    exp_addr.push_back(a);
                    exp_data.push_back(d);
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Memory models, read data one cycle after en

    task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
        if (exp_addr.size() == 0) begin
            stop_with_failure($sformatf("Store of %h to address %h came after the last expected store",
                                        data, addr));
        end else begin
            check_value("dmem_req.addr", addr, exp_addr.pop_front());
            check_value("dmem_req.wdata", data, exp_data.pop_front());
        end
    endtask

    always @(posedge clk) begin
        if (imem_req.en) begin
            imem_rdata <= imem[imem_req.addr[9:2]];
        end
        if (dmem_req.en && dmem_req.we) begin
            dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
            check_store(dmem_req.addr, dmem_req.wdata);
            quiet_count = 0;
        end else begin
            if (dmem_req.en) begin
                dmem_rdata <= dmem[dmem_req.addr[9:2]];
            end
            quiet_count = quiet_count + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        rst        = 1'b1;
        imem_rdata = '0;
        dmem_rdata = '0;
        load_tests();
        if (num_words == 0 || exp_addr.size() == 0) begin
            stop_with_failure("The tests file holds no program words or no expected stores");
        end
        // 6 cycles per word covers a load, times 20 for loops
        cycle_limit = num_words * 6 * 20 + 200;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // Program ends in a self-loop, so wait for a quiet stretch after the last store
        while (!(exp_addr.size() == 0 && quiet_count >= 50) && cycle_count < cycle_limit) begin
            @(negedge clk);
            cycle_count++;
        end

        if (exp_addr.size() == 0 && quiet_count >= 50) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stop_with_failure($sformatf("Timeout after %0d cycles with %0d expected stores missing",
                                        cycle_count, exp_addr.size()));
        end
    end

endmodule

/* dv/mini_rv32_tests.txt */
// I <word>: program word at the next word address, from 0
// D <addr> <word>: initial data word; E <addr> <word>: expected store, in program order
I 00500093 // addi x1, x0, 5
I ffd00113 // addi x2, x0, -3
I 002081b3 // add  x3, x1, x2
I 20302023 // sw   x3, 0x200(x0)
I 40208233 // sub  x4, x1, x2
I 20402223 // sw   x4, 0x204(x0)
I 001122b3 // slt  x5, x2, x1
I 20502423 // sw   x5, 0x208(x0)
I 00113333 // sltu x6, x2, x1
I 20602623 // sw   x6, 0x20c(x0)
I 0020c3b3 // xor  x7, x1, x2
I 20702823 // sw   x7, 0x210(x0)
I 0020e433 // or   x8, x1, x2
I 20802a23 // sw   x8, 0x214(x0)
I 0020f4b3 // and  x9, x1, x2
I 20902c23 // sw   x9, 0x218(x0)
I ffe12513 // slti  x10, x2, -2
I 20a02e23 // sw    x10, 0x21c(x0)
I fff0b593 // sltiu x11, x1, -1
I 22b02023 // sw    x11, 0x220(x0)
I fff0c613 // xori  x12, x1, -1
I 22c02223 // sw    x12, 0x224(x0)
I 123456b7 // lui   x13, 0x12345
I 22d02423 // sw    x13, 0x228(x0)
I 00001717 // auipc x14, 0x1 at 0x60
I 22e02623 // sw    x14, 0x22c(x0)
I 00700013 // addi  x0, x0, 7
I 22002823 // sw    x0, 0x230(x0)
I 10002783 // lw    x15, 0x100(x0)
I 10402803 // lw    x16, 0x104(x0)
I 22f02a23 // sw    x15, 0x234(x0)
I 23002c23 // sw    x16, 0x238(x0)
I 00108463 // beq  x1, x1, +8 taken
I 3e002823 // sw   x0, 0x3f0(x0) wrong path
I 00208463 // beq  x1, x2, +8 not taken
I 24102023 // sw   x1, 0x240(x0)
I 00209463 // bne  x1, x2, +8 taken
I 3e002823 // sw   x0, 0x3f0(x0) wrong path
I 00109463 // bne  x1, x1, +8 not taken
I 24102223 // sw   x1, 0x244(x0)
I 00114463 // blt  x2, x1, +8 taken
I 3e002823 // sw   x0, 0x3f0(x0) wrong path
I 0020c463 // blt  x1, x2, +8 not taken
I 24102423 // sw   x1, 0x248(x0)
I 0020d463 // bge  x1, x2, +8 taken
I 3e002823 // sw   x0, 0x3f0(x0) wrong path
I 00115463 // bge  x2, x1, +8 not taken
I 24102623 // sw   x1, 0x24c(x0)
I 0020e463 // bltu x1, x2, +8 taken
I 3e002823 // sw   x0, 0x3f0(x0) wrong path
I 00116463 // bltu x2, x1, +8 not taken
I 24102823 // sw   x1, 0x250(x0)
I 00117463 // bgeu x2, x1, +8 taken
I 3e002823 // sw   x0, 0x3f0(x0) wrong path
I 0020f463 // bgeu x1, x2, +8 not taken
I 24102a23 // sw   x1, 0x254(x0)
I 00c008ef // jal  x17, +12 at 0xe0
I 3e002823 // sw   x0, 0x3f0(x0) wrong path
I 3e002823 // sw   x0, 0x3f0(x0) wrong path
I 25102c23 // sw   x17, 0x258(x0)
I 0f500993 // addi x19, x0, 0xf5
I 00898967 // jalr x18, 8(x19) to 0xfc, bit 0 cleared
I 3e002823 // sw   x0, 0x3f0(x0) wrong path
I 25202e23 // sw   x18, 0x25c(x0)
I 0000006f // jal  x0, 0 self-loop
D 100 cafef00d
D 104 80000001
E 200 00000002
E 204 00000008
E 208 00000001
E 20c 00000000
E 210 fffffff8
E 214 fffffffd
E 218 00000005
E 21c 00000001
E 220 00000001
E 224 fffffffa
E 228 12345000
E 22c 00001060
E 230 00000000
E 234 cafef00d
E 238 80000001
E 240 00000005
E 244 00000005
E 248 00000005
E 24c 00000005
E 250 00000005
E 254 00000005
E 258 000000e4
E 25c 000000f8

/* mini_rv32.f */
logic/mini_rv32_pkg.sv
logic/core_control.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/register_file.sv
logic/alu_unit.sv
logic/branch_unit.sv
logic/load_store_unit.sv
logic/mini_rv32.sv
dv/mini_rv32_asserts.sv
dv/tb_mini_rv32.sv

/* Makefile */
SRCS := $(wildcard logic/*.sv dv/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_mini_rv32: mini_rv32.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		--top-module tb_mini_rv32 -f mini_rv32.f

run: obj_dir/Vtb_mini_rv32 dv/mini_rv32_tests.txt
	obj_dir/Vtb_mini_rv32 > sim.log 2>&1 || echo "Simulation FAILED" >> sim.log
	cat sim.log
	! grep -q "Simulation FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
